/* vis_ctl.f */
vis_pkg.sv
vis_decode.sv
vis_gsr_file.sv
vis_result.sv
vis_ctl.sv
vis_ctl_assertions.sv
tb_vis_ctl.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f vis_ctl.f --top-module tb_vis_ctl -Mdir obj_dir
	./obj_dir/Vtb_vis_ctl > sim.log 2>&1 || true
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_vis_ctl.sv */
////////////////////////////////////////
// Drives directed and random operations into vis_ctl
// and checks them against a GSR model and a reference control word
////////////////////////////////////////
`timescale 1ns/1ps

module tb_vis_ctl;
   import vis_pkg::*;

   logic        clk;
   logic        reset;
   vis_op_req_t op_in;
   gsr_wr_t     gsr_wr;
   fsr_rnd_t    fsr_rnd;
   vis_ctl_t    ctl_out;

   gsr_t        gsr_model [num_threads];
   vis_op_req_t pending;
   string       pending_name;
   vis_ctl_t    exp_word;
   vis_ctl_t    exp_q [$];
   string       name_q [$];
   string       test_name;
   integer      seed;
   int          ctl_errors;
   int          gsr_errors;
   int          other_errors;
   int          wait_cycles;

   vis_ctl UUT (
      .clk     (clk),
      .reset   (reset),
      .op_in   (op_in),
      .gsr_wr  (gsr_wr),
      .fsr_rnd (fsr_rnd),
      .ctl_out (ctl_out)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic vis_ctl_t reference_ctl(input vis_op_req_t req, input gsr_t g,
                                              input fsr_rnd_t fsr);
      vis_ctl_t  c;
      log_func_e f;
      logic      is_add;
      logic      is_align;
      logic      is_logic;
      logic      is_siam;
      logic      is_aa;
      logic      bad_rs1;
      logic      bad_rs2;
      logic      bad_siam;
      f        = log_func_e'(req.opf[4:1]);
      is_add   = (req.opf[8:3] == 6'b001010);
      is_align = (req.opf == 9'b0_0100_1000);
      is_logic = (req.opf[8:5] == 4'b0011);
      is_siam  = (req.opf == 9'b0_1000_0001);
      is_aa    = (req.opf[8:2] == 7'b0000110) && !req.opf[0];
      bad_rs1  = (req.frs1 != 5'd0) &&
                 (is_siam || (is_logic && (f inside {log_zero, log_one, log_src2, log_not2})));
      bad_rs2  = (req.frs2 != 5'd0) &&
                 is_logic && (f inside {log_zero, log_one, log_src1, log_not1});
      bad_siam = is_siam && ((req.frd != 5'd0) || (req.frs2[4:3] != 2'b00));
      c.valid   = 1'b1;
      c.illegal = !(is_add || is_align || is_logic || is_siam || is_aa) ||
                  bad_rs1 || bad_rs2 || bad_siam;
      c.nofrf   = is_siam || is_aa || (is_logic && (f inside {log_zero, log_one}));
      c.wen     = !c.illegal && !is_siam && !is_aa;
      c.out_sel = is_add ? out_add : (is_align ? out_align : out_log);
      c.add32    = req.opf[1];
      c.subtract = req.opf[2];
      c.cin      = req.opf[2];
      if (f inside {log_or, log_nand, log_ornot1, log_ornot2}) begin
         c.log_sel = sel_nand;
      end else if (f inside {log_and, log_nor, log_andnot1, log_andnot2}) begin
         c.log_sel = sel_nor;
      end else if (f inside {log_xor, log_xnor}) begin
         c.log_sel = sel_xor;
      end else begin
         c.log_sel = sel_pass;
      end
      c.invert_rs1 = f inside {log_not1, log_or, log_and, log_ornot2, log_andnot2};
      c.invert_rs2 = f inside {log_not2, log_or, log_and, log_ornot1, log_andnot1, log_xnor};
      c.pass_rs1    = f inside {log_src1, log_not1};
      c.pass_rs2    = f inside {log_src2, log_not2};
      c.pass_const  = !(c.pass_rs1 || c.pass_rs2);
      c.constant    = (f == log_one);
      c.align_shift = g.align;
      c.fpu_rnd     = g.rnd[2] ? g.rnd[1:0] : fsr;
      return c;
   endfunction

   task automatic update_gsr_model(input vis_op_req_t req, input logic illegal);
      if (!illegal && (req.opf == 9'b0_1000_0001)) begin
         gsr_model[req.tid].rnd = req.siam_rnd;
      end
      if (!illegal && (req.opf[8:2] == 7'b0000110) && !req.opf[0]) begin
         // Little-endian form keeps the negated offset
         gsr_model[req.tid].align = req.opf[1] ? align_t'(3'd0 - req.addr_offset)
                                               : req.addr_offset;
      end
   endtask

   task automatic check_ctl(input string name, input vis_ctl_t exp, input vis_ctl_t act);
      if (act !== exp) begin
         $display("[FAIL] %s: control word expected %h actual %h", name, exp, act);
         ctl_errors++;
      end
   endtask

   task automatic check_gsr(input string name, input int t, input gsr_t exp, input gsr_t act);
      if (act !== exp) begin
         $display("[FAIL] %s: GSR thread %0d expected %h actual %h", name, t, exp, act);
         gsr_errors++;
      end
   endtask

   ////////////////////////////////////////
   // Compare and model step at mid-cycle
   ////////////////////////////////////////
   always @(negedge clk) begin
      if (reset) begin
         for (int t = 0; t < num_threads; t++) begin
            gsr_model[t] = '0;
         end
         pending = '0;
         exp_q.delete();
         name_q.delete();
      end else begin
         if (ctl_out.valid && (exp_q.size() == 0)) begin
            $display("ERROR: control word strobed with no operation outstanding");
            other_errors++;
         end else if (ctl_out.valid) begin
            check_ctl(name_q.pop_front(), exp_q.pop_front(), ctl_out);
         end else if (exp_q.size() != 0) begin
            $display("ERROR: control word for %s did not arrive", name_q[0]);
            other_errors++;
            exp_q.delete(0);
            name_q.delete(0);
         end
         for (int t = 0; t < num_threads; t++) begin
            check_gsr(test_name, t, gsr_model[t], UUT.u_gsr_file.gsr_q[t]);
         end
         // Operation in decode this cycle followed by the cycle-end GSR commits
         if (pending.valid) begin
            exp_word = reference_ctl(pending, gsr_model[pending.tid], fsr_rnd);
            exp_q.push_back(exp_word);
            name_q.push_back(pending_name);
            update_gsr_model(pending, exp_word.illegal);
         end
         if (gsr_wr.valid) begin
            gsr_model[gsr_wr.tid] = gsr_wr.gsr;
         end
         pending      = op_in;
         pending_name = test_name;
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   function automatic vis_op_req_t make_op(input tid_t tid, input opf_t opf, input freg_t frs1,
                                           input freg_t frs2, input freg_t frd, input rnd_t rnd,
                                           input align_t off);
      vis_op_req_t op;
      op.valid       = 1'b1;
      op.tid         = tid;
      op.opf         = opf;
      op.frs1        = frs1;
      op.frs2        = frs2;
      op.frd         = frd;
      op.siam_rnd    = rnd;
      op.addr_offset = off;
      return op;
   endfunction

   task automatic drive_cycle(input string name, input vis_op_req_t op, input gsr_wr_t wr,
                              input fsr_rnd_t fsr);
      @(posedge clk);
      #1;
      test_name = name;
      op_in     = op;
      gsr_wr    = wr;
      fsr_rnd   = fsr;
   endtask

   task automatic pulse_reset(input vis_op_req_t op);
      @(posedge clk);
      #1;
      test_name = "reset";
      reset     = 1'b1;
      op_in     = op;
      gsr_wr    = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      op_in = '0;
   endtask

   task automatic random_cycle();
      vis_op_req_t op;
      gsr_wr_t     wr;
      logic [31:0] r;
      logic [31:0] s;
      logic [31:0] w;
      r = $random(seed);
      s = $random(seed);
      w = $random(seed);
      op.valid = r[0] | r[1];
      op.tid   = r[3:2];
      case (r[6:4])
         3'd0:       op.opf = {6'b001010, r[8:7], r[13]};
         3'd1:       op.opf = 9'b0_0100_1000;
         3'd2, 3'd3: op.opf = {4'b0011, r[12:9], r[13]};
         3'd4:       op.opf = 9'b0_1000_0001;
         3'd5:       op.opf = {7'b0000110, r[7], 1'b0};
         default:    op.opf = r[31:23];
      endcase
      // Register fields are mostly zero and sometimes not
      op.frs1        = (s[2:0] == 3'd0) ? s[7:3] : 5'd0;
      op.frs2        = (s[10:8] == 3'd0) ? s[15:11] : 5'd0;
      op.frd         = (s[18:16] == 3'd0) ? s[23:19] : 5'd0;
      op.siam_rnd    = s[26:24];
      op.addr_offset = s[29:27];
      wr.valid = (w[2:0] == 3'd0);
      wr.tid   = w[4:3];
      wr.gsr   = w[10:5];
      drive_cycle("random", op, wr, w[12:11]);
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      op_in        = '0;
      gsr_wr       = '0;
      fsr_rnd      = '0;
      pending      = '0;
      pending_name = "reset";
      test_name    = "reset";
      seed         = 14801;
      ctl_errors   = 0;
      gsr_errors   = 0;
      other_errors = 0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      for (int f = 0; f < 16; f++) begin
         drive_cycle("logic", make_op(2'd0, {4'b0011, 4'(f), 1'b0}, 0, 0, 0, 0, 0), '0, 2'd1);
      end
      for (int k = 0; k < 4; k++) begin
         drive_cycle("add", make_op(2'd1, {6'b001010, 2'(k), 1'b0}, 1, 2, 3, 0, 0), '0, 2'd2);
      end

      drive_cycle("illegal", make_op(2'd0, 9'h1ff, 0, 0, 0, 3'd7, 3'd5), '0, 2'd0);
      drive_cycle("illegal", make_op(2'd0, 9'h060, 5'd3, 0, 0, 0, 0), '0, 2'd0);
      drive_cycle("illegal", make_op(2'd0, 9'h074, 0, 5'd5, 0, 0, 0), '0, 2'd0);
      drive_cycle("illegal", make_op(2'd0, 9'h081, 0, 0, 5'd1, 3'd7, 0), '0, 2'd0);
      drive_cycle("illegal", make_op(2'd0, 9'h081, 0, 5'd8, 0, 3'd6, 0), '0, 2'd0);

      drive_cycle("siam", make_op(2'd1, 9'h081, 0, 0, 0, 3'b110, 0), '0, 2'd1);
      drive_cycle("siam", make_op(2'd1, 9'h07c, 0, 0, 0, 0, 0), '0, 2'd1);
      drive_cycle("siam", make_op(2'd2, 9'h07c, 0, 0, 0, 0, 0), '0, 2'd3);
      drive_cycle("siam", make_op(2'd1, 9'h081, 0, 0, 0, 3'b010, 0), '0, 2'd3);
      drive_cycle("siam", make_op(2'd1, 9'h050, 0, 0, 0, 0, 0), '0, 2'd3);

      drive_cycle("alignaddr", make_op(2'd2, 9'h018, 1, 2, 3, 0, 3'd5), '0, 2'd0);
      drive_cycle("alignaddr", make_op(2'd2, 9'h048, 1, 2, 3, 0, 0), '0, 2'd0);
      drive_cycle("alignaddr", make_op(2'd2, 9'h01a, 1, 2, 3, 0, 3'd5), '0, 2'd0);
      drive_cycle("alignaddr", make_op(2'd2, 9'h048, 1, 2, 3, 0, 0), '0, 2'd0);

      // Explicit write lands in the same cycle as the siam decode
      drive_cycle("gsr_wr", make_op(2'd3, 9'h081, 0, 0, 0, 3'b111, 0), '0, 2'd0);
      drive_cycle("gsr_wr", make_op(2'd3, 9'h07c, 0, 0, 0, 0, 0),
                  '{valid: 1'b1, tid: 2'd3, gsr: '{rnd: 3'b101, align: 3'd6}}, 2'd0);
      drive_cycle("gsr_wr", make_op(2'd3, 9'h048, 0, 0, 0, 0, 0), '0, 2'd2);

      // Reset lands with operations still in flight and GSR fields set
      drive_cycle("reset", make_op(2'd1, 9'h081, 0, 0, 0, 3'b111, 0), '0, 2'd0);
      drive_cycle("reset", make_op(2'd2, 9'h081, 0, 0, 0, 3'b110, 0), '0, 2'd0);
      pulse_reset(make_op(2'd0, 9'h07c, 0, 0, 0, 0, 0));
      drive_cycle("reset", make_op(2'd3, 9'h048, 0, 0, 0, 0, 0), '0, 2'd2);

      for (int i = 0; i < 400; i++) begin
         random_cycle();
      end

      drive_cycle("drain", '0, '0, 2'd0);
      wait_cycles = 0;
      while ((exp_q.size() != 0 || pending.valid) && (wait_cycles < 20)) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (exp_q.size() != 0 || pending.valid) begin
         $display("ERROR: timeout waiting for outstanding control words");
         other_errors++;
      end

      $display("Errors: ctl %0d, gsr %0d, other %0d", ctl_errors, gsr_errors, other_errors);
      if ((ctl_errors + gsr_errors + other_errors) == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* vis_ctl_assertions.sv */
////////////////////////////////////////
// Port-level protocol checks, bound into vis_ctl
////////////////////////////////////////
`timescale 1ns/1ps

module vis_ctl_assertions (
   input logic                 clk,
   input logic                 reset,
   input vis_pkg::vis_op_req_t op_in,
   input vis_pkg::vis_ctl_t    ctl_out
);
   import vis_pkg::*;

   // Fixed two-stage latency, no dropped and no extra strobes
   valid_latency: assert property (@(posedge clk) disable iff (reset)
      (!$past(reset, 1) && !$past(reset, 2)) |-> (ctl_out.valid == $past(op_in.valid, 2)))
      else $error("ctl_out.valid does not follow op_in.valid two cycles later");

   no_valid_in_reset: assert property (@(posedge clk)
      (reset && $past(reset)) |-> !ctl_out.valid)
      else $error("ctl_out.valid set while reset is held");

   out_sel_defined: assert property (@(posedge clk) disable iff (reset)
      ctl_out.valid |-> (!$isunknown(ctl_out.out_sel) &&
                         (ctl_out.out_sel inside {out_add, out_log, out_align})))
      else $error("ctl_out.out_sel undefined on a valid control word");

endmodule

bind vis_ctl vis_ctl_assertions u_assertions (
   .clk     (clk),
   .reset   (reset),
   .op_in   (op_in),
   .ctl_out (ctl_out)
);

/* vis_ctl.sv */
////////////////////////////////////////
// VIS control top: decode, GSR file and result stage
// Operation in cycle N gives the control word in cycle N+2
////////////////////////////////////////
`timescale 1ns/1ps

module vis_ctl (
   input  logic                 clk,
   input  logic                 reset,
   input  vis_pkg::vis_op_req_t op_in,
   input  vis_pkg::gsr_wr_t     gsr_wr,
   input  vis_pkg::fsr_rnd_t    fsr_rnd,
   output vis_pkg::vis_ctl_t    ctl_out
);
   import vis_pkg::*;

   vis_op_t  dec_op;
   vis_chk_t dec_chk;
   gsr_t     thr_gsr;

   vis_decode u_decode (
      .clk     (clk),
      .reset   (reset),
      .op_in   (op_in),
      .dec_op  (dec_op),
      .dec_chk (dec_chk)
   );

   // GSR read and update share the decoded cycle
   vis_gsr_file u_gsr_file (
      .clk     (clk),
      .reset   (reset),
      .dec_op  (dec_op),
      .dec_chk (dec_chk),
      .gsr_wr  (gsr_wr),
      .thr_gsr (thr_gsr)
   );

   vis_result u_result (
      .clk     (clk),
      .reset   (reset),
      .dec_op  (dec_op),
      .dec_chk (dec_chk),
      .thr_gsr (thr_gsr),
      .fsr_rnd (fsr_rnd),
      .ctl_out (ctl_out)
   );

endmodule

/* vis_result.sv */
////////////////////////////////////////
// Result stage: builds the registered datapath control word
// from the decoded operation and the thread's GSR
////////////////////////////////////////
`timescale 1ns/1ps

module vis_result (
   input  logic              clk,
   input  logic              reset,
   input  vis_pkg::vis_op_t  dec_op,
   input  vis_pkg::vis_chk_t dec_chk,
   input  vis_pkg::gsr_t     thr_gsr,
   input  vis_pkg::fsr_rnd_t fsr_rnd,
   output vis_pkg::vis_ctl_t ctl_out
);
   import vis_pkg::*;

   log_func_e func;
   logic      no_result;
   vis_ctl_t  ctl_d;

   assign func      = dec_op.log_func;
   assign no_result = (dec_op.cls == cls_siam) || (dec_op.cls == cls_alignaddr);

   always_comb begin
      ctl_d.valid   = dec_op.valid;
      ctl_d.illegal = dec_chk.illegal;
      ctl_d.nofrf   = dec_chk.nofrf;
      ctl_d.wen     = dec_op.valid && !dec_chk.illegal && !no_result;

      // Output mux
      case (dec_op.cls)
         cls_add:   ctl_d.out_sel = out_add;
         cls_align: ctl_d.out_sel = out_align;
         default:   ctl_d.out_sel = out_log;
      endcase

      // Adder
      ctl_d.add32    = dec_op.add32;
      ctl_d.subtract = dec_op.subtract;
      ctl_d.cin      = dec_op.subtract;

      // Logic unit, built on nand/nor/xor with optional input inversion
      case (func)
         log_or, log_nand, log_ornot1, log_ornot2:    ctl_d.log_sel = sel_nand;
         log_and, log_nor, log_andnot1, log_andnot2:  ctl_d.log_sel = sel_nor;
         log_xor, log_xnor:                           ctl_d.log_sel = sel_xor;
         default:                                     ctl_d.log_sel = sel_pass;
      endcase
      ctl_d.invert_rs1 = func inside {log_not1, log_or, log_and, log_ornot2, log_andnot2};
      ctl_d.invert_rs2 = func inside {log_not2, log_or, log_and, log_ornot1, log_andnot1,
                                      log_xnor};
      ctl_d.pass_rs1   = func inside {log_src1, log_not1};
      ctl_d.pass_rs2   = func inside {log_src2, log_not2};
      ctl_d.pass_const = !(ctl_d.pass_rs1 || ctl_d.pass_rs2);
      ctl_d.constant   = (func == log_one);

      // falign shift and rounding mode
      ctl_d.align_shift = thr_gsr.align;
      ctl_d.fpu_rnd     = thr_gsr.rnd[2] ? thr_gsr.rnd[1:0] : fsr_rnd;
   end

   always_ff @(posedge clk) begin
      ctl_out <= ctl_d;
      if (reset) begin
         ctl_out.valid <= 1'b0;
      end
   end

endmodule

/* vis_gsr_file.sv */
////////////////////////////////////////
// Per-thread GSR rounding and align fields
// Reads the issuing thread and commits updates at cycle end
////////////////////////////////////////
`timescale 1ns/1ps

module vis_gsr_file (
   input  logic              clk,
   input  logic              reset,
   input  vis_pkg::vis_op_t  dec_op,
   input  vis_pkg::vis_chk_t dec_chk,
   input  vis_pkg::gsr_wr_t  gsr_wr,
   output vis_pkg::gsr_t     thr_gsr
);
   import vis_pkg::*;

   gsr_t   gsr_q [num_threads];
   logic   op_update;
   logic   siam_wr;
   logic   aa_wr;
   align_t aa_align;

   // Value seen by the issuing thread, before this cycle's commit
   assign thr_gsr = gsr_q[dec_op.tid];

   assign op_update = dec_op.valid && !dec_chk.illegal;
   assign siam_wr   = op_update && (dec_op.cls == cls_siam);
   assign aa_wr     = op_update && (dec_op.cls == cls_alignaddr);

   // Little-endian alignaddress stores the negated offset
   assign aa_align = dec_op.little ? align_t'(~dec_op.addr_offset + 3'd1)
                                   : dec_op.addr_offset;

   ////////////////////////////////////////
   // Update, explicit write has priority
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      for (int t = 0; t < num_threads; t++) begin
         if (reset) begin
            gsr_q[t] <= '0;
         end else if (gsr_wr.valid && (gsr_wr.tid == tid_t'(t))) begin
            gsr_q[t] <= gsr_wr.gsr;
         end else if (dec_op.tid == tid_t'(t)) begin
            if (siam_wr) begin
               gsr_q[t].rnd <= dec_op.siam_rnd;
            end
            if (aa_wr) begin
               gsr_q[t].align <= aa_align;
            end
         end
      end
   end

endmodule

/* vis_decode.sv */
////////////////////////////////////////
// Decode stage: classifies opf, checks register fields
// and registers the decoded operation one cycle later
////////////////////////////////////////
`timescale 1ns/1ps

module vis_decode (
   input  logic                 clk,
   input  logic                 reset,
   input  vis_pkg::vis_op_req_t op_in,
   output vis_pkg::vis_op_t     dec_op,
   output vis_pkg::vis_chk_t    dec_chk
);
   import vis_pkg::*;

   vis_class_e cls;
   log_func_e  func;
   logic       rs1_must_be_zero;
   logic       rs2_must_be_zero;
   logic       illegal_rs1;
   logic       illegal_rs2;
   logic       illegal_siam;
   vis_op_t    op_d;
   vis_chk_t   chk_d;

   ////////////////////////////////////////
   // Opcode class
   ////////////////////////////////////////
   always_comb begin
      if ((op_in.opf & opf_add_mask) == opf_add_base) begin
         cls = cls_add;
      end else if (op_in.opf == opf_falign) begin
         cls = cls_align;
      end else if ((op_in.opf & opf_logic_mask) == opf_logic_base) begin
         cls = cls_logic;
      end else if (op_in.opf == opf_siam) begin
         cls = cls_siam;
      end else if ((op_in.opf & opf_alignaddr_mask) == opf_alignaddr) begin
         cls = cls_alignaddr;
      end else begin
         cls = cls_illegal;
      end
   end

   assign func = log_func_e'(op_in.opf[4:1]);

   // Functions that ignore a source need that field left at zero
   assign rs1_must_be_zero = (cls == cls_siam) ||
      ((cls == cls_logic) && (func inside {log_zero, log_one, log_src2, log_not2}));
   assign rs2_must_be_zero =
      (cls == cls_logic) && (func inside {log_zero, log_one, log_src1, log_not1});

   assign illegal_rs1  = rs1_must_be_zero && (op_in.frs1 != '0);
   assign illegal_rs2  = rs2_must_be_zero && (op_in.frs2 != '0);
   // siam carries no destination and only a 3-bit mode in frs2
   assign illegal_siam = (cls == cls_siam) &&
                         ((op_in.frd != '0) || op_in.frs2[4] || op_in.frs2[3]);

   always_comb begin
      chk_d.illegal = (cls == cls_illegal) || illegal_rs1 || illegal_rs2 || illegal_siam;
      chk_d.nofrf   = (cls == cls_siam) || (cls == cls_alignaddr) ||
                      ((cls == cls_logic) && (func inside {log_zero, log_one}));
   end

   always_comb begin
      op_d.valid       = op_in.valid;
      op_d.tid         = op_in.tid;
      op_d.cls         = cls;
      op_d.log_func    = func;
      op_d.subtract    = op_in.opf[2];
      op_d.add32       = op_in.opf[1];
      op_d.little      = op_in.opf[1];
      op_d.siam_rnd    = op_in.siam_rnd;
      op_d.addr_offset = op_in.addr_offset;
   end

   // Only the strobe is cleared, the payload follows it
   always_ff @(posedge clk) begin
      dec_op  <= op_d;
      dec_chk <= chk_d;
      if (reset) begin
         dec_op.valid <= 1'b0;
      end
   end

endmodule

/* vis_pkg.sv */
////////////////////////////////////////
// Shared types and opf encodings for the VIS control block
// Imported by every RTL file and by the testbench
////////////////////////////////////////
package vis_pkg;

   localparam int num_threads = 4;

   typedef logic [1:0] tid_t;
   typedef logic [8:0] opf_t;
   typedef logic [4:0] freg_t;
   // Bit 2 selects the GSR rounding mode over the FSR one
   typedef logic [2:0] rnd_t;
   typedef logic [2:0] align_t;
   typedef logic [1:0] fsr_rnd_t;

   ////////////////////////////////////////
   // Opcode encodings
   ////////////////////////////////////////
   // Partitioned add, bit 2 subtract, bit 1 32-bit
   localparam opf_t opf_add_base       = 9'b0_0101_0000;
   localparam opf_t opf_add_mask       = 9'b1_1111_1000;
   localparam opf_t opf_falign         = 9'b0_0100_1000;
   // Logic function sits in bits 4 to 1
   localparam opf_t opf_logic_base     = 9'b0_0110_0000;
   localparam opf_t opf_logic_mask     = 9'b1_1110_0000;
   localparam opf_t opf_siam           = 9'b0_1000_0001;
   // Bit 1 is the little-endian form
   localparam opf_t opf_alignaddr      = 9'b0_0001_1000;
   localparam opf_t opf_alignaddr_mask = 9'b1_1111_1101;

   typedef enum logic [2:0] {
      cls_add, cls_align, cls_logic, cls_siam, cls_alignaddr, cls_illegal
   } vis_class_e;

   // Encoded as opf bits 4 to 1
   typedef enum logic [3:0] {
      log_zero, log_nor, log_andnot2, log_not2,
      log_andnot1, log_not1, log_xor, log_nand,
      log_and, log_xnor, log_src1, log_ornot2,
      log_src2, log_ornot1, log_or, log_one
   } log_func_e;

   typedef enum logic [1:0] {sel_pass, sel_nand, sel_nor, sel_xor} log_sel_e;
   typedef enum logic [1:0] {out_add, out_log, out_align} out_sel_e;

   ////////////////////////////////////////
   // Interface and pipeline structs
   ////////////////////////////////////////
   typedef struct packed {
      logic   valid;
      tid_t   tid;
      opf_t   opf;
      freg_t  frs1;
      freg_t  frs2;
      freg_t  frd;
      rnd_t   siam_rnd;
      align_t addr_offset;
   } vis_op_req_t;

   typedef struct packed {
      logic       valid;
      tid_t       tid;
      vis_class_e cls;
      log_func_e  log_func;
      logic       subtract;
      logic       add32;
      logic       little;
      rnd_t       siam_rnd;
      align_t     addr_offset;
   } vis_op_t;

   typedef struct packed {
      logic illegal;
      logic nofrf;
   } vis_chk_t;

   typedef struct packed {
      rnd_t   rnd;
      align_t align;
   } gsr_t;

   typedef struct packed {
      logic valid;
      tid_t tid;
      gsr_t gsr;
   } gsr_wr_t;

   typedef struct packed {
      logic     valid;
      logic     illegal;
      logic     nofrf;
      logic     wen;
      out_sel_e out_sel;
      logic     add32;
      logic     subtract;
      logic     cin;
      log_sel_e log_sel;
      logic     invert_rs1;
      logic     invert_rs2;
      logic     pass_rs1;
      logic     pass_rs2;
      logic     pass_const;
      logic     constant;
      align_t   align_shift;
      fsr_rnd_t fpu_rnd;
   } vis_ctl_t;

endpackage
